// ==== hw/arith_pkg.sv ====
// Operands and results are unsigned and wrap modulo 2^data_width, and no signed or saturating form exists
package arith_pkg;

    localparam int data_width = 16;                 // Operand and result width

    // Opcode of the combining stage
    typedef enum logic
    {
        op_add = 1'b0,                              // a^5 + b^5, carry out in the top bit
        op_sub = 1'b1                               // a^5 - b^5, borrow in the top bit
    } op_e;

    // One upstream item
    typedef struct packed
    {
        op_e                     op;
        logic [data_width - 1:0] a;
        logic [data_width - 1:0] b;
    } operand_t;

    // One downstream item and one FIFO entry
    typedef struct packed
    {
        logic [data_width - 1:0] value;
        logic                    carry;             // Carry on add, borrow on subtract
    } result_t;

    // Register contents of one power pipeline stage
    typedef struct packed
    {
        logic                    vld;
        op_e                     op;                // Travels along as a tag
        logic [data_width - 1:0] x;                 // Original operand
        logic [data_width - 1:0] product;           // Running power of x
    } pow_stage_t;

endpackage

// ==== hw/flow_pkg.sv ====
// Latencies are fixed at build time, and the FIFO depth must cover every item in flight
package flow_pkg;

    // ##################################################################
    // Pipeline latencies

    localparam int pow_depth     = 5;               // x^5 needs five registered stages
    localparam int combine_depth = 1;               // Adder or subtractor is one register

    // Every item that can be in flight between acceptance and the FIFO
    localparam int total_depth = pow_depth + combine_depth;

    // ##################################################################
    // Credit counting

    // Counts from 0 up to total_depth inclusive
    localparam int credit_width = $clog2(total_depth + 1);

endpackage

// ==== hw/pow_5_pipelined_without_flow_control.sv ====
// The pipeline never stalls, so the consumer must always accept down_vld in the cycle it appears
`timescale 1ns/1ps

module pow_5_pipelined_without_flow_control
(
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                up_vld,
    input  arith_pkg::op_e                      up_op,
    input  logic [arith_pkg::data_width - 1:0]  up_data,

    output logic                                down_vld,
    output arith_pkg::op_e                      down_op,
    output logic [arith_pkg::data_width - 1:0]  down_data
);

    import arith_pkg::*;
    import flow_pkg::*;

    // ##################################################################
    // Stage inputs and registers

    pow_stage_t stage_d [pow_depth];                // Value presented to each stage
    pow_stage_t stage_q [pow_depth];                // Value held by each stage

    always_comb
    begin
        // The first stage starts from a product of one, so it holds x itself
        stage_d[0] = '{
            vld:     up_vld,
            op:      up_op,
            x:       up_data,
            product: data_width'(1)
        };

        for (int i = 1; i < pow_depth; i++)
        begin
            stage_d[i] = stage_q[i - 1];
        end
    end

    // ##################################################################
    // Multiply stages

    generate
        for (genvar i = 0; i < pow_depth; i++)
        begin : g_stage
            always_ff @(posedge clk or posedge rst)
            begin
                if (rst)
                begin
                    stage_q[i].vld <= 1'b0;     // Only the valid bit is cleared
                end
                else
                begin
                    stage_q[i].vld     <= stage_d[i].vld;
                    stage_q[i].op      <= stage_d[i].op;
                    stage_q[i].x       <= stage_d[i].x;

                    // Product keeps only the low data_width bits
                    stage_q[i].product <= stage_d[i].product * stage_d[i].x;
                end
            end
        end
    endgenerate

    // ##################################################################
    // Output

    // Last stage holds x^5 five cycles after up_vld
    assign down_vld  = stage_q[pow_depth - 1].vld;
    assign down_op   = stage_q[pow_depth - 1].op;
    assign down_data = stage_q[pow_depth - 1].product;

endmodule

// ==== hw/power_combine.sv ====
// Both powers must arrive in the same cycle, and op and in_vld are taken from one side only
`timescale 1ns/1ps

module power_combine
(
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                in_vld,
    input  arith_pkg::op_e                      op,
    input  logic [arith_pkg::data_width - 1:0]  pow_a,
    input  logic [arith_pkg::data_width - 1:0]  pow_b,

    output logic                                out_vld,
    output arith_pkg::result_t                  out_data
);

    import arith_pkg::*;

    logic [data_width:0] wide;                      // One extra bit for carry or borrow

    // Zero-extended operands put the carry or the borrow into the top bit
    always_comb
    begin
        case (op)
            op_add:  wide = {1'b0, pow_a} + {1'b0, pow_b};
            op_sub:  wide = {1'b0, pow_a} - {1'b0, pow_b};  // Top bit set when pow_b > pow_a
            default: wide = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_vld <= 1'b0;
        end
        else
        begin
            out_vld <= in_vld;
        end
    end

    always_ff @(posedge clk)
    begin
        out_data.value <= wide[data_width - 1:0];
        out_data.carry <= wide[data_width];
    end

endmodule

// ==== hw/flip_flop_fifo_with_counter.sv ====
// A push into a full FIFO without a pop in the same cycle is ignored, as is a pop from an empty one
`timescale 1ns/1ps

module flip_flop_fifo_with_counter
#(
    parameter int depth = flow_pkg::total_depth
)
(
    input  logic                clk,
    input  logic                rst,

    input  logic                push,
    input  logic                pop,
    input  arith_pkg::result_t  write_data,
    output arith_pkg::result_t  read_data,

    output logic                empty,
    output logic                full
);

    import arith_pkg::*;

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width = $clog2(depth + 1);

    // ##################################################################
    // Storage and pointers

    result_t                mem [depth];            // Entries carry no reset

    logic [ptr_width - 1:0] wr_ptr;
    logic [ptr_width - 1:0] rd_ptr;
    logic [cnt_width - 1:0] cnt;

    logic                   wr_en;
    logic                   rd_en;

    // A pop frees the head slot on the same edge, so a full FIFO may take a push
    assign wr_en = push & (~full | pop);
    assign rd_en = pop & ~empty;

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= write_data;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end
        else
        begin
            // Depth need not be a power of two, so pointers wrap explicitly
            if (wr_en)
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + ptr_width'(1);

            if (rd_en)
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + ptr_width'(1);

            case ({wr_en, rd_en})
                2'b10:   cnt <= cnt + cnt_width'(1);
                2'b01:   cnt <= cnt - cnt_width'(1);
                default: cnt <= cnt;            // Both or neither leave occupancy alone
            endcase
        end
    end

    // ##################################################################
    // Outputs

    assign read_data = mem[rd_ptr];                 // Head stays put until popped
    assign empty     = (cnt == '0);
    assign full      = (cnt == cnt_width'(depth));

endmodule

// ==== hw/pow_5_sum_with_credit_counter.sv ====
// Latency is fixed at 7 cycles to an empty FIFO, and up_rdy drops once 6 items are in flight
`timescale 1ns/1ps

module pow_5_sum_with_credit_counter
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 up_vld,            // Upstream
    output logic                 up_rdy,
    input  arith_pkg::operand_t  up_data,

    output logic                 down_vld,          // Downstream
    input  logic                 down_rdy,
    output arith_pkg::result_t   down_data
);

    import arith_pkg::*;
    import flow_pkg::*;

    logic                    accept;                // Input taken this edge
    logic                    pop;                   // Output taken this edge

    logic                    pipe_a_vld;
    op_e                     pipe_a_op;
    logic [data_width - 1:0] pow_a;
    logic [data_width - 1:0] pow_b;

    logic                    comb_vld;
    result_t                 comb_data;

    logic                    fifo_empty;

    // ##################################################################
    // Power pipelines

    pow_5_pipelined_without_flow_control pipe_a
    (
        .clk       (clk),
        .rst       (rst),
        .up_vld    (accept),
        .up_op     (up_data.op),
        .up_data   (up_data.a),
        .down_vld  (pipe_a_vld),
        .down_op   (pipe_a_op),
        .down_data (pow_a)
    );

    // Valid and opcode match pipe_a by construction, so only the power is taken
    pow_5_pipelined_without_flow_control pipe_b
    (
        .clk       (clk),
        .rst       (rst),
        .up_vld    (accept),
        .up_op     (up_data.op),
        .up_data   (up_data.b),
        .down_vld  (),
        .down_op   (),
        .down_data (pow_b)
    );

    power_combine i_combine
    (
        .clk      (clk),
        .rst      (rst),
        .in_vld   (pipe_a_vld),
        .op       (pipe_a_op),
        .pow_a    (pow_a),
        .pow_b    (pow_b),
        .out_vld  (comb_vld),
        .out_data (comb_data)
    );

    // ##################################################################
    // Output FIFO

    flip_flop_fifo_with_counter #(.depth(total_depth)) i_fifo
    (
        .clk        (clk),
        .rst        (rst),
        .push       (comb_vld),                     // Credits guarantee room
        .pop        (pop),
        .write_data (comb_data),
        .read_data  (down_data),
        .empty      (fifo_empty),
        .full       ()
    );

    // ##################################################################
    // Credit counter and handshake

    logic [credit_width - 1:0] credit;
    logic [credit_width - 1:0] credit_next;

    always_comb
    begin
        case ({accept, pop})
            2'b10:   credit_next = credit - credit_width'(1);
            2'b01:   credit_next = credit + credit_width'(1);
            default: credit_next = credit;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            credit <= credit_width'(total_depth);   // One credit per FIFO slot
        end
        else
        begin
            credit <= credit_next;
        end
    end

    assign up_rdy   = (credit != '0);               // Independent of up_vld
    assign accept   = up_vld & up_rdy;

    // A result is offered for as long as the FIFO holds one
    assign down_vld = ~fifo_empty;
    assign pop      = down_vld & down_rdy;

endmodule

// ==== bench/tb_pow_5_sum.sv ====
// Reads bench/pow_5_sum_stimulus.txt relative to the working directory, so run from the project root
`timescale 1ns/1ps

module tb_pow_5_sum;

    import arith_pkg::*;
    import flow_pkg::*;

    localparam int idle_limit = 200;                // Cycles a loop may go without any transfer

    logic      clk;
    logic      rst;
    logic      up_vld;
    logic      up_rdy;
    operand_t  up_data;
    logic      down_vld;
    logic      down_rdy;
    result_t   down_data;

    operand_t    op_q [$];                          // Operations in file order
    result_t     exp_q [$];                         // Expected result for each operation

    logic [31:0] lfsr;
    int          error_count;
    int          check_count;
    int          test_count;
    int          test_fail_count;
    int          in_flight;                         // Accepted but not yet delivered

    pow_5_sum_with_credit_counter i_dut
    (
        .clk       (clk),
        .rst       (rst),
        .up_vld    (up_vld),
        .up_rdy    (up_rdy),
        .up_data   (up_data),
        .down_vld  (down_vld),
        .down_rdy  (down_rdy),
        .down_data (down_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ##################################################################
    // Helpers

    // Fibonacci form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [31:0] op_v, a_v, b_v, val_v, car_v;
        operand_t    item;
        result_t     res;

        fd = $fopen("bench/pow_5_sum_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: the stimulus file could not be opened");
            error_count++;
            return;
        end
        while (!$feof(fd))
        begin
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() == 0 || line[0] == "#")  // Column notes at the top
                continue;
            n = $sscanf(line, "%h %h %h %h %h", op_v, a_v, b_v, val_v, car_v);
            if (n == 5)
            begin
                item.op    = op_e'(op_v[0]);
                item.a     = a_v[data_width - 1:0];
                item.b     = b_v[data_width - 1:0];
                res.value  = val_v[data_width - 1:0];
                res.carry  = car_v[0];
                op_q.push_back(item);
                exp_q.push_back(res);
            end
            else if (n > 0)
            begin
                $display("ERROR: a stimulus line does not hold five fields: %s", line);
                error_count++;
            end
        end
        $fclose(fd);
        if (op_q.size() == 0)
        begin
            $display("ERROR: the stimulus file holds no operations");
            error_count++;
        end
    endtask

    // One loop drives both ports so the LFSR bits are always drawn in the same order
    task automatic run_stream(input bit pressure);
        int      sent;
        int      got;
        int      idle;
        logic    gap;
        logic    rdy;
        result_t expected;

        sent      = 0;
        got       = 0;
        idle      = 0;
        in_flight = 0;
        while (got < exp_q.size() && idle < idle_limit)
        begin
            @(posedge clk);
            idle++;

            // Ready exactly while a credit is left
            check_value("up_rdy", 32'(in_flight < total_depth), 32'(up_rdy));

            if (up_vld && up_rdy)
            begin
                sent++;
                in_flight++;
                idle = 0;
            end
            if (down_vld && down_rdy)
            begin
                expected = exp_q[got];
                check_value("down_data.value", 32'(expected.value), 32'(down_data.value));
                check_value("down_data.carry", 32'(expected.carry), 32'(down_data.carry));
                got++;
                in_flight--;
                idle = 0;
            end

            if (in_flight > total_depth)
            begin
                $display("ERROR at %0t: %0d items in flight, more than the FIFO holds",
                         $time, in_flight);
                error_count++;
            end
            if (in_flight < 0)
            begin
                $display("ERROR at %0t: a result came out with no input behind it", $time);
                error_count++;
            end

            if (pressure)
            begin
                take_bit(gap);
                take_bit(rdy);
            end
            else
            begin
                gap = 1'b0;
                rdy = 1'b1;
            end

            // An offer that was not taken stays on the bus unchanged
            if (!(up_vld && !up_rdy))
            begin
                if (sent < op_q.size() && !gap)
                begin
                    up_vld  <= 1'b1;
                    up_data <= op_q[sent];
                end
                else
                    up_vld <= 1'b0;
            end
            down_rdy <= rdy;
        end

        if (idle >= idle_limit)
        begin
            $display("ERROR at %0t: timed out with %0d of %0d results delivered",
                     $time, got, exp_q.size());
            error_count++;
        end
        up_vld   <= 1'b0;
        down_rdy <= 1'b1;
    endtask

    // Nothing may follow the last result, and every credit must come back
    task automatic expect_idle();
        int cycles;

        cycles = 0;
        while (cycles < total_depth + 4)
        begin
            @(posedge clk);
            cycles++;
            if (down_vld)
            begin
                $display("ERROR at %0t: a result appeared after every line was delivered",
                         $time);
                error_count++;
                break;
            end
        end
        check_value("up_rdy", 32'd1, 32'(up_rdy));
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before)
            $display("test %0d %s: ok", test_count, name);
        else
        begin
            test_fail_count++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    // ##################################################################
    // Sequence

    initial
    begin
        int errors_before;

        rst             = 1'b1;
        up_vld          = 1'b0;
        up_data         = '0;
        down_rdy        = 1'b0;
        lfsr            = 32'h8998_e074;
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        test_fail_count = 0;
        in_flight       = 0;

        load_stimulus();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        errors_before = error_count;
        @(posedge clk);
        check_value("up_rdy", 32'd1, 32'(up_rdy));
        check_value("down_vld", 32'd0, 32'(down_vld));
        report_test("state after reset", errors_before);

        errors_before = error_count;
        down_rdy <= 1'b1;
        run_stream(1'b0);
        expect_idle();
        report_test("ordered stream with down_rdy high", errors_before);

        errors_before = error_count;
        run_stream(1'b1);
        expect_idle();
        report_test("stream under back-pressure", errors_before);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, test_fail_count, check_count, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== bench/pow_5_sum_stimulus.txt ====
# op a b value carry, all hex; op 0 adds a^5 and b^5, op 1 subtracts b^5 from a^5
# value is the wrapped 16-bit result, carry is the carry out or the borrow
0 0000 0000 0000 0
0 0001 0001 0002 0
0 0002 0003 0113 0
1 0003 0002 00d3 0
1 0002 0003 ff2d 1
0 0005 0007 4ddc 0
1 0005 0007 ca8e 1
0 000a 0009 6d49 1
1 000a 0009 9ff7 1
0 ffff 0001 0000 1
1 ffff 0001 fffe 0
0 0010 0002 0020 0
1 0100 0002 ffe0 1
1 0003 0004 fcf3 1
0 000b 000c 411b 1
1 000c 000b 56e5 0
0 0fff fffe 4fdf 1
1 0fff fffe 501f 1
0 8000 0101 0501 0
1 0101 00ff 0002 0
0 0007 0006 6007 0
1 0006 0007 dcb9 1
0 0013 0013 9086 1
1 0013 00ff c344 0
1 0000 0000 0000 0
1 ffff ffff 0000 0

// ==== sim.f ====
hw/arith_pkg.sv
hw/flow_pkg.sv
hw/pow_5_pipelined_without_flow_control.sv
hw/power_combine.sv
hw/flip_flop_fifo_with_counter.sv
hw/pow_5_sum_with_credit_counter.sv
bench/tb_pow_5_sum.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_pow_5_sum
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
